//--- Makefile
VERILATOR  := verilator
TOP        := tb_rv_core
FILE_LIST  := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# the run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module tb_rv_core;

    localparam int CLK_PERIOD  = 10;
    localparam int RESET_LEN   = 4;
    localparam int IMEM_WORDS  = 256;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 4 + 11 + 13 + 10 + 3 + 3;   // instructions run per test
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + NUM_TESTS * RESET_LEN + 20;

    logic                clk;
    logic                rst_n;
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] instr_addr;
    logic [`RV_XLEN-1:0] a0;
    logic [31:0]         imem [IMEM_WORDS];
    int unsigned         wr_ptr;
    logic [15:0]         lfsr;

    rv_core i_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .instr_i      (instr),
        .instr_addr_o (instr_addr),
        .a0_o         (a0)
    );

    assign instr = imem[instr_addr[9:2]];   // word-indexed fetch

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("** FAIL **");
        $fatal(1, "simulation hung");
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input rv_pkg::opcode_e op, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rv_pkg::OP_LUI};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic start_program();
        wr_ptr = 0;
        for (int k = 0; k < IMEM_WORDS; k++)
        begin
            imem[k] = enc_i(rv_pkg::OP_IMM, 5'd0, 3'b000, 5'd0, 12'(k));   // tagged no-op
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[wr_ptr] = word;
        wr_ptr++;
    endtask

    // addi sign-extends the low part, so round the upper part up
    task automatic emit_li(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] hi;
        hi = value[31:12] + {19'b0, value[11]};
        emit(enc_u(rd, hi));
        emit(enc_i(rv_pkg::OP_IMM, rd, 3'b000, rd, value[11:0]));
    endtask

    task automatic reset_core();
        rst_n = 1'b0;
        repeat (RESET_LEN) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic step(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic test_reset();
        start_program();
        reset_core();
        check_value("reset pc", 32'h0, instr_addr);
        for (int k = 1; k <= 4; k++)
        begin
            step(1);
            check_value("pc advance", 32'(4 * k), instr_addr);
        end
    endtask

    task automatic test_arith();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a  = rand_bits(32);
        b  = rand_bits(32);
        sh = 5'(rand_bits(5));
        start_program();
        emit_li(5'd5, a);
        emit_li(5'd6, b);
        emit(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd10));
        emit(enc_r(7'h20, 5'd6, 5'd5, 3'b000, 5'd10));   // sub
        emit(enc_r(7'h00, 5'd6, 5'd5, 3'b111, 5'd10));
        emit(enc_r(7'h00, 5'd6, 5'd5, 3'b110, 5'd10));
        emit(enc_r(7'h00, 5'd6, 5'd5, 3'b100, 5'd10));
        emit(enc_r(7'h00, 5'd6, 5'd5, 3'b010, 5'd10));   // slt
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b001, 5'd5, {7'b0, sh}));
        reset_core();
        step(4);
        step(1);
        check_value("add", a + b, a0);
        step(1);
        check_value("sub", a - b, a0);
        step(1);
        check_value("and", a & b, a0);
        step(1);
        check_value("or", a | b, a0);
        step(1);
        check_value("xor", a ^ b, a0);
        step(1);
        // differing signs decide alone
        check_value("slt", (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b}, a0);
        step(1);
        check_value("slli", a << sh, a0);
    endtask

    task automatic test_load_store();
        logic [31:0] w;
        logic [11:0] v;
        logic [31:0] addr;
        logic [31:0] merged;
        w    = rand_bits(32);
        v    = 12'(rand_bits(12));
        addr = rand_bits(10) & 32'(`RV_DMEM_BYTES - 4);   // word aligned and in range
        start_program();
        emit_li(5'd8, w);
        emit(enc_i(rv_pkg::OP_IMM, 5'd7, 3'b000, 5'd0, addr[11:0]));
        emit(enc_i(rv_pkg::OP_IMM, 5'd9, 3'b000, 5'd0, v));
        emit(enc_s(3'b010, 5'd7, 5'd8, 12'd0));
        emit(enc_i(rv_pkg::OP_LOAD, 5'd10, 3'b010, 5'd7, 12'd0));
        emit(enc_i(rv_pkg::OP_LOAD, 5'd10, 3'b000, 5'd7, 12'd1));
        emit(enc_i(rv_pkg::OP_LOAD, 5'd10, 3'b001, 5'd7, 12'd2));
        emit(enc_i(rv_pkg::OP_LOAD, 5'd10, 3'b100, 5'd7, 12'd3));
        emit(enc_i(rv_pkg::OP_LOAD, 5'd10, 3'b101, 5'd7, 12'd0));
        emit(enc_s(3'b000, 5'd7, 5'd9, 12'd1));   // sb into byte 1
        emit(enc_s(3'b001, 5'd7, 5'd9, 12'd2));   // sh into upper half
        emit(enc_i(rv_pkg::OP_LOAD, 5'd10, 3'b010, 5'd7, 12'd0));
        reset_core();
        step(5);
        step(1);
        check_value("lw", w, a0);
        step(1);
        check_value("lb", {{24{w[15]}}, w[15:8]}, a0);
        step(1);
        check_value("lh", {{16{w[31]}}, w[31:16]}, a0);
        step(1);
        check_value("lbu", {24'b0, w[31:24]}, a0);
        step(1);
        check_value("lhu", {16'b0, w[15:0]}, a0);
        merged        = w;
        merged[15:8]  = v[7:0];
        merged[31:16] = {{4{v[11]}}, v};   // store data was sign-extended by addi
        step(3);
        check_value("merged word", merged, a0);
    endtask

    task automatic test_branches();
        logic [10:0] k;
        k = 11'(rand_bits(11));
        start_program();
        emit(enc_i(rv_pkg::OP_IMM, 5'd5, 3'b000, 5'd0, {1'b0, k}));
        emit(enc_i(rv_pkg::OP_IMM, 5'd6, 3'b000, 5'd0, {1'b0, k}));
        emit(enc_i(rv_pkg::OP_IMM, 5'd11, 3'b000, 5'd0, {1'b0, k ^ 11'd1}));
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, 12'd0));
        emit(enc_b(3'b000, 5'd5, 5'd6, 13'd8));   // beq taken
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd10, 12'd1));
        emit(enc_b(3'b000, 5'd5, 5'd11, 13'd8));
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd10, 12'd2));
        emit(enc_b(3'b001, 5'd5, 5'd11, 13'd8));  // bne taken
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd10, 12'd4));
        emit(enc_b(3'b001, 5'd5, 5'd6, 13'd8));
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd10, 12'd8));
        reset_core();
        step(10);
        check_value("branch markers", 32'd10, a0);   // only the not-taken paths add
        check_value("branch pc", 32'd48, instr_addr);
    endtask

    task automatic test_jumps();
        start_program();
        emit(enc_j(5'd10, 21'd8));
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, 12'd1));
        emit(enc_i(rv_pkg::OP_IMM, 5'd12, 3'b000, 5'd0, 12'd20));
        emit(enc_i(rv_pkg::OP_JALR, 5'd10, 3'b000, 5'd12, 12'd5));   // 25 rounds down to 24
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, 12'd1));
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, 12'd1));
        reset_core();
        step(1);
        check_value("jal link", 32'd4, a0);
        check_value("jal target", 32'd8, instr_addr);
        step(2);
        check_value("jalr link", 32'd16, a0);
        check_value("jalr target", 32'd24, instr_addr);
    endtask

    task automatic test_x0();
        start_program();
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, 12'd55));
        emit(enc_i(rv_pkg::OP_IMM, 5'd0, 3'b000, 5'd0, 12'd123));
        emit(enc_i(rv_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, 12'd0));   // copy x0
        reset_core();
        step(1);
        check_value("a0 preset", 32'd55, a0);
        step(2);
        check_value("x0 copy", 32'd0, a0);
    endtask

    initial
    begin
        rst_n = 1'b0;
        lfsr  = 16'd87;
        start_program();
        @(negedge clk);
        test_reset();
        test_arith();
        test_load_store();
        test_branches();
        test_jumps();
        test_x0();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- hdl/alu.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a_i,
    input  logic [`RV_XLEN-1:0] b_i,
    input  rv_pkg::alu_op_e     alu_ctrl_i,
    output logic [`RV_XLEN-1:0] result_o,
    output logic                zero_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb
    begin
        case (alu_ctrl_i)
            rv_pkg::ALU_ADD:    result_o = a_i + b_i;
            rv_pkg::ALU_SUB:    result_o = a_i - b_i;
            rv_pkg::ALU_AND:    result_o = a_i & b_i;
            rv_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_pkg::ALU_SLL:    result_o = a_i << shamt;
            rv_pkg::ALU_SLT:    // signed compare
            begin
                result_o = ($signed(a_i) < $signed(b_i)) ? `RV_XLEN'(1) : '0;
            end
            rv_pkg::ALU_PASS_B: result_o = b_i;
            default:            result_o = '0;
        endcase
    end

    // branches read this after a subtract
    assign zero_o = (result_o == '0);

endmodule

//--- hdl/control_unit.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module control_unit (
    input  logic [`RV_XLEN-1:0]  instr_i,
    input  logic                 zero_i,
    output logic                 reg_write_o,
    output logic                 alu_src_o,
    output rv_pkg::alu_op_e      alu_ctrl_o,
    output rv_pkg::imm_sel_e     imm_src_o,
    output rv_pkg::result_sel_e  result_src_o,
    output rv_pkg::pc_sel_e      pc_src_o,
    output rv_pkg::load_kind_e   load_kind_o,
    output rv_pkg::store_kind_e  store_kind_o
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;

    assign opcode    = rv_pkg::opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];   // sub vs add

    always_comb
    begin
        // no-op unless an opcode below claims the instruction
        reg_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        alu_ctrl_o   = rv_pkg::ALU_ADD;
        imm_src_o    = rv_pkg::IMM_I;
        result_src_o = rv_pkg::RES_ALU;
        pc_src_o     = rv_pkg::PC_NEXT;
        load_kind_o  = rv_pkg::LD_W;
        store_kind_o = rv_pkg::ST_NONE;

        case (opcode)
            rv_pkg::OP_LOAD:
            begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;      // base + offset
                imm_src_o    = rv_pkg::IMM_I;
                result_src_o = rv_pkg::RES_MEM;
                case (funct3)
                    3'b000:  load_kind_o = rv_pkg::LD_B;
                    3'b001:  load_kind_o = rv_pkg::LD_H;
                    3'b100:  load_kind_o = rv_pkg::LD_BU;
                    3'b101:  load_kind_o = rv_pkg::LD_HU;
                    default: load_kind_o = rv_pkg::LD_W;
                endcase
            end
            rv_pkg::OP_STORE:
            begin
                alu_src_o = 1'b1;
                imm_src_o = rv_pkg::IMM_S;
                case (funct3)
                    3'b000:  store_kind_o = rv_pkg::ST_B;
                    3'b001:  store_kind_o = rv_pkg::ST_H;
                    3'b010:  store_kind_o = rv_pkg::ST_W;
                    default: store_kind_o = rv_pkg::ST_NONE;   // undefined width
                endcase
            end
            rv_pkg::OP_REG:
            begin
                reg_write_o = 1'b1;
                case (funct3)
                    3'b000:  alu_ctrl_o = funct7_b5 ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b010:  alu_ctrl_o = rv_pkg::ALU_SLT;
                    3'b100:  alu_ctrl_o = rv_pkg::ALU_XOR;
                    3'b110:  alu_ctrl_o = rv_pkg::ALU_OR;
                    3'b111:  alu_ctrl_o = rv_pkg::ALU_AND;
                    default: alu_ctrl_o = rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OP_IMM:
            begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = rv_pkg::IMM_I;
                alu_ctrl_o  = (funct3 == 3'b001) ? rv_pkg::ALU_SLL : rv_pkg::ALU_ADD;
            end
            rv_pkg::OP_BRANCH:
            begin
                imm_src_o  = rv_pkg::IMM_B;
                alu_ctrl_o = rv_pkg::ALU_SUB;   // compare through zero flag
                case (funct3)
                    3'b000:  pc_src_o = zero_i ? rv_pkg::PC_BRANCH : rv_pkg::PC_NEXT;
                    3'b001:  pc_src_o = zero_i ? rv_pkg::PC_NEXT : rv_pkg::PC_BRANCH;
                    default: pc_src_o = rv_pkg::PC_NEXT;
                endcase
            end
            rv_pkg::OP_JAL:
            begin
                reg_write_o  = 1'b1;
                imm_src_o    = rv_pkg::IMM_J;
                result_src_o = rv_pkg::RES_PC4;   // link
                pc_src_o     = rv_pkg::PC_BRANCH;
            end
            rv_pkg::OP_JALR:
            begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                imm_src_o    = rv_pkg::IMM_I;
                result_src_o = rv_pkg::RES_PC4;
                pc_src_o     = rv_pkg::PC_JALR;   // target from alu
            end
            rv_pkg::OP_LUI:
            begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = rv_pkg::IMM_U;
                alu_ctrl_o  = rv_pkg::ALU_PASS_B;
            end
            default:
            begin
                reg_write_o  = 1'b0;
                store_kind_o = rv_pkg::ST_NONE;
                pc_src_o     = rv_pkg::PC_NEXT;
            end
        endcase
    end

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module data_mem (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic [`RV_XLEN-1:0]  addr_i,
    input  logic [`RV_XLEN-1:0]  wdata_i,
    input  rv_pkg::store_kind_e  store_kind_i,
    input  rv_pkg::load_kind_e   load_kind_i,
    output logic [`RV_XLEN-1:0]  rdata_o
);

    localparam int AW = $clog2(`RV_DMEM_BYTES);

    logic [7:0]    mem [`RV_DMEM_BYTES];
    logic [AW-1:0] a0;
    logic [AW-1:0] a1;
    logic [AW-1:0] a2;
    logic [AW-1:0] a3;
    logic [7:0]    b0;
    logic [7:0]    b1;

    // byte lanes wrap around the array
    assign a0 = addr_i[AW-1:0];
    assign a1 = a0 + AW'(1);
    assign a2 = a0 + AW'(2);
    assign a3 = a0 + AW'(3);

    always_ff @(posedge clk_i)
    begin
        if (rst_n_i)
        begin
            case (store_kind_i)
                rv_pkg::ST_B:
                begin
                    mem[a0] <= wdata_i[7:0];
                end
                rv_pkg::ST_H:
                begin
                    mem[a0] <= wdata_i[7:0];
                    mem[a1] <= wdata_i[15:8];
                end
                rv_pkg::ST_W:
                begin
                    mem[a0] <= wdata_i[7:0];
                    mem[a1] <= wdata_i[15:8];
                    mem[a2] <= wdata_i[23:16];
                    mem[a3] <= wdata_i[31:24];
                end
                default: ;   // no store this cycle
            endcase
        end
    end

    assign b0 = mem[a0];
    assign b1 = mem[a1];

    always_comb
    begin
        case (load_kind_i)
            rv_pkg::LD_B:  rdata_o = {{(`RV_XLEN-8){b0[7]}}, b0};
            rv_pkg::LD_H:  rdata_o = {{(`RV_XLEN-16){b1[7]}}, b1, b0};
            rv_pkg::LD_BU: rdata_o = {{(`RV_XLEN-8){1'b0}}, b0};
            rv_pkg::LD_HU: rdata_o = {{(`RV_XLEN-16){1'b0}}, b1, b0};
            default:       rdata_o = {mem[a3], mem[a2], b1, b0};   // little endian word
        endcase
    end

endmodule

//--- hdl/imm_extend.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module imm_extend (
    input  logic [`RV_XLEN-1:0] instr_i,
    input  rv_pkg::imm_sel_e    imm_src_i,
    output logic [`RV_XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];   // all formats sign from bit 31

    always_comb
    begin
        case (imm_src_i)
            rv_pkg::IMM_I:
                imm_o = {{(`RV_XLEN-12){sign}}, instr_i[31:20]};
            rv_pkg::IMM_S:
                imm_o = {{(`RV_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            rv_pkg::IMM_B:   // halfword offset
                imm_o = {{(`RV_XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            rv_pkg::IMM_J:
                imm_o = {{(`RV_XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            rv_pkg::IMM_U:   // upper 20 bits, low bits zero
                imm_o = {instr_i[31:12], 12'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module reg_file (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [4:0]          rs1_i,
    input  logic [4:0]          rs2_i,
    input  logic [4:0]          rd_i,
    input  logic                we_i,
    input  logic [`RV_XLEN-1:0] wd_i,
    output logic [`RV_XLEN-1:0] rd1_o,
    output logic [`RV_XLEN-1:0] rd2_o,
    output logic [`RV_XLEN-1:0] a0_o
);

    localparam logic [4:0] A0_IDX = 5'd10;

    logic [`RV_XLEN-1:0] regs [`RV_REGS];

    always_ff @(posedge clk_i)
    begin
        if (rst_n_i && we_i && (rd_i != '0))   // x0 never written
        begin
            regs[rd_i] <= wd_i;
        end
    end

    assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];
    assign a0_o  = regs[A0_IDX];   // result tap

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module rv_core (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [`RV_XLEN-1:0] instr_i,
    output logic [`RV_XLEN-1:0] instr_addr_o,
    output logic [`RV_XLEN-1:0] a0_o
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_target;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rd1;
    logic [`RV_XLEN-1:0] rd2;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] result;
    logic                zero;
    logic                reg_write;
    logic                alu_src;
    rv_pkg::alu_op_e     alu_ctrl;
    rv_pkg::imm_sel_e    imm_src;
    rv_pkg::result_sel_e result_src;
    rv_pkg::pc_sel_e     pc_src;
    rv_pkg::load_kind_e  load_kind;
    rv_pkg::store_kind_e store_kind;

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            pc <= '0;
        end
        else
        begin
            pc <= pc_next;
        end
    end

    assign pc_plus4  = pc + `RV_XLEN'(4);
    assign pc_target = pc + imm;   // branches and jal

    always_comb
    begin
        case (pc_src)
            rv_pkg::PC_BRANCH: pc_next = pc_target;
            rv_pkg::PC_JALR:   pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
            default:           pc_next = pc_plus4;
        endcase
    end

    assign alu_b = alu_src ? imm : rd2;

    always_comb
    begin
        case (result_src)
            rv_pkg::RES_MEM: result = load_data;
            rv_pkg::RES_PC4: result = pc_plus4;   // link value
            default:         result = alu_result;
        endcase
    end

    control_unit i_control_unit (
        .instr_i      (instr_i),
        .zero_i       (zero),
        .reg_write_o  (reg_write),
        .alu_src_o    (alu_src),
        .alu_ctrl_o   (alu_ctrl),
        .imm_src_o    (imm_src),
        .result_src_o (result_src),
        .pc_src_o     (pc_src),
        .load_kind_o  (load_kind),
        .store_kind_o (store_kind)
    );

    imm_extend i_imm_extend (
        .instr_i   (instr_i),
        .imm_src_i (imm_src),
        .imm_o     (imm)
    );

    reg_file i_reg_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rs1_i   (instr_i[19:15]),
        .rs2_i   (instr_i[24:20]),
        .rd_i    (instr_i[11:7]),
        .we_i    (reg_write),
        .wd_i    (result),
        .rd1_o   (rd1),
        .rd2_o   (rd2),
        .a0_o    (a0_o)
    );

    alu i_alu (
        .a_i        (rd1),
        .b_i        (alu_b),
        .alu_ctrl_i (alu_ctrl),
        .result_o   (alu_result),
        .zero_o     (zero)
    );

    data_mem i_data_mem (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .addr_i       (alu_result),
        .wdata_i      (rd2),
        .store_kind_i (store_kind),
        .load_kind_i  (load_kind),
        .rdata_o      (load_data)
    );

    assign instr_addr_o = pc;

endmodule

//--- hdl/rv_pkg.sv
package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'b000,
        ALU_SUB    = 3'b001,
        ALU_AND    = 3'b010,
        ALU_OR     = 3'b011,
        ALU_XOR    = 3'b100,
        ALU_SLL    = 3'b101,
        ALU_SLT    = 3'b110,
        ALU_PASS_B = 3'b111   // lui
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} imm_sel_e;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_sel_e;

    typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JALR} pc_sel_e;

    // encoded as the load funct3
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_BU = 3'b100,
        LD_HU = 3'b101
    } load_kind_e;

    typedef enum logic [1:0] {ST_NONE, ST_B, ST_H, ST_W} store_kind_e;

endpackage

//--- hdl/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath and address width
`define RV_XLEN 32

// architectural registers x0 to x31
`define RV_REGS 32

// data memory size in bytes as a power of two
`define RV_DMEM_BYTES 1024

`endif

//--- list.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/control_unit.sv
hdl/imm_extend.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/data_mem.sv
hdl/rv_core.sv
bench/tb_rv_core.sv
